/* common/t08_pkg.sv */
`default_nettype none

package t08_pkg;

    typedef logic [31:0] word_t;     // Data, addresses and instructions
    typedef logic [4:0]  reg_addr_t; // Register index
    typedef logic [1:0]  wb_sel_t;   // Register write source

    localparam wb_sel_t WB_ZERO  = 2'b00; // Writes zero
    localparam wb_sel_t WB_MEM   = 2'b01; // Load data
    localparam wb_sel_t WB_FETCH = 2'b10; // Link address
    localparam wb_sel_t WB_ALU   = 2'b11; // ALU result

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL} branch_t;

    typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, HALT} cpu_state_t;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

/* common/t08_regs_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface t08_regs_if;

    t08_pkg::reg_addr_t address_r1, address_r2, address_rd;
    logic               en_read_1, en_read_2, en_write;
    t08_pkg::wb_sel_t   data_in_control;
    t08_pkg::word_t     data_in_frommemory, data_in_frominstructionfetch, data_in_fromalu;
    t08_pkg::word_t     data_out_r1, data_out_r2;

    modport regfile (
        input  address_r1, address_r2, address_rd,
        input  en_read_1, en_read_2, en_write, data_in_control,
        input  data_in_frommemory, data_in_frominstructionfetch, data_in_fromalu,
        output data_out_r1, data_out_r2
    );

    modport ctrl (output en_read_1, en_read_2, en_write, data_in_control);

    modport dec (output address_r1, address_r2, address_rd);

    // Each block drives only its own source
    modport dpath (
        output data_in_frommemory, data_in_frominstructionfetch, data_in_fromalu,
        input  data_out_r1, data_out_r2
    );

endinterface

`default_nettype wire

/* registers/t08_registers.sv */
`timescale 1ns/100ps
`default_nettype none

module t08_registers (
    input  logic       clk,
    input  logic       rst_n,
    t08_regs_if.regfile regs
);

    t08_pkg::word_t data [32];
    t08_pkg::word_t data_in;
    t08_pkg::word_t r1_hold; // Last value shown on read port 1
    t08_pkg::word_t r2_hold;

    always_comb begin : select_data_in
        case (regs.data_in_control)
            t08_pkg::WB_MEM:   data_in = regs.data_in_frommemory;
            t08_pkg::WB_FETCH: data_in = regs.data_in_frominstructionfetch;
            t08_pkg::WB_ALU:   data_in = regs.data_in_fromalu;
            default:           data_in = '0;
        endcase
    end

    always_comb begin : read_ports
        if (regs.en_read_1) begin
            regs.data_out_r1 = data[regs.address_r1];
        end else begin
            regs.data_out_r1 = r1_hold;
        end

        if (regs.en_read_2) begin
            regs.data_out_r2 = data[regs.address_r2];
        end else begin
            regs.data_out_r2 = r2_hold;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data    <= '{default: '0};
            r1_hold <= '0;
            r2_hold <= '0;
        end else begin
            // x0 stays hardwired to zero
            if (regs.en_write && (regs.address_rd != '0)) begin
                data[regs.address_rd] <= data_in;
            end
            r1_hold <= regs.data_out_r1; // Keep what was shown
            r2_hold <= regs.data_out_r2;
        end
    end

endmodule

`default_nettype wire

/* source/t08_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module t08_alu (
    t08_regs_if.dpath         regs,
    input  t08_pkg::alu_op_t  alu_op,
    input  logic              use_imm,
    input  t08_pkg::word_t    imm,
    output t08_pkg::word_t    result,
    output logic              zero
);

    t08_pkg::word_t op_a;
    t08_pkg::word_t op_b;

    assign op_a = regs.data_out_r1;
    assign op_b = use_imm ? imm : regs.data_out_r2; // Immediate or rs2

    always_comb begin
        case (alu_op)
            t08_pkg::ALU_ADD:    result = op_a + op_b;
            t08_pkg::ALU_SUB:    result = op_a - op_b;
            t08_pkg::ALU_AND:    result = op_a & op_b;
            t08_pkg::ALU_OR:     result = op_a | op_b;
            t08_pkg::ALU_XOR:    result = op_a ^ op_b;
            t08_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            t08_pkg::ALU_SLL:    result = op_a << op_b[4:0];
            t08_pkg::ALU_SRL:    result = op_a >> op_b[4:0];
            t08_pkg::ALU_PASS_B: result = op_b; // lui
            default:             result = '0;
        endcase
    end

    assign zero = (result == '0); // Branch compare uses SUB

    assign regs.data_in_fromalu = result;

endmodule

`default_nettype wire

/* source/t08_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module t08_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ir_load,
    input  t08_pkg::word_t    instr,
    t08_regs_if.dec           regs,
    output t08_pkg::alu_op_t  alu_op,
    output logic              use_imm,
    output t08_pkg::word_t    imm,
    output t08_pkg::wb_sel_t  wb_sel,
    output t08_pkg::branch_t  branch,
    output logic              is_load,
    output logic              is_store,
    output logic              is_halt
);

    t08_pkg::word_t ir;
    logic [6:0]     opcode;
    logic [2:0]     funct3;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= t08_pkg::NOP_INSTR;
        end else if (ir_load) begin
            ir <= instr; // Closing edge of FETCH
        end
    end

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    assign regs.address_r1 = ir[19:15];
    assign regs.address_r2 = ir[24:20];
    assign regs.address_rd = ir[11:7];

    always_comb begin
        imm     = {{20{ir[31]}}, ir[31:20]}; // I format unless overridden
        alu_op  = t08_pkg::ALU_ADD;
        use_imm = 1'b0;
        wb_sel  = t08_pkg::WB_ZERO;
        branch  = t08_pkg::BR_NONE;
        case (opcode)
            t08_pkg::OP_R: begin
                wb_sel = t08_pkg::WB_ALU;
                case (funct3)
                    3'b000:  alu_op = ir[30] ? t08_pkg::ALU_SUB : t08_pkg::ALU_ADD;
                    3'b001:  alu_op = t08_pkg::ALU_SLL;
                    3'b010:  alu_op = t08_pkg::ALU_SLT;
                    3'b100:  alu_op = t08_pkg::ALU_XOR;
                    3'b101:  alu_op = t08_pkg::ALU_SRL;
                    3'b110:  alu_op = t08_pkg::ALU_OR;
                    3'b111:  alu_op = t08_pkg::ALU_AND;
                    default: alu_op = t08_pkg::ALU_ADD;
                endcase
            end
            t08_pkg::OP_I: begin
                wb_sel  = t08_pkg::WB_ALU;
                use_imm = 1'b1;
                case (funct3)
                    3'b010:  alu_op = t08_pkg::ALU_SLT;
                    3'b100:  alu_op = t08_pkg::ALU_XOR;
                    3'b110:  alu_op = t08_pkg::ALU_OR;
                    3'b111:  alu_op = t08_pkg::ALU_AND;
                    default: alu_op = t08_pkg::ALU_ADD; // addi and unsupported shifts
                endcase
            end
            t08_pkg::OP_LUI: begin
                imm     = {ir[31:12], 12'b0};
                alu_op  = t08_pkg::ALU_PASS_B;
                use_imm = 1'b1;
                wb_sel  = t08_pkg::WB_ALU;
            end
            t08_pkg::OP_LOAD: begin
                use_imm = 1'b1;
                wb_sel  = t08_pkg::WB_MEM;
            end
            t08_pkg::OP_STORE: begin
                imm     = {{20{ir[31]}}, ir[31:25], ir[11:7]};
                use_imm = 1'b1;
            end
            t08_pkg::OP_BRANCH: begin
                imm    = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
                alu_op = t08_pkg::ALU_SUB; // Zero flag means equal
                if (funct3 == 3'b000) begin
                    branch = t08_pkg::BR_BEQ;
                end else if (funct3 == 3'b001) begin
                    branch = t08_pkg::BR_BNE;
                end
            end
            t08_pkg::OP_JAL: begin
                imm    = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                wb_sel = t08_pkg::WB_FETCH; // Link is pc + 4
                branch = t08_pkg::BR_JAL;
            end
            default: ;
        endcase
    end

    assign is_load  = (opcode == t08_pkg::OP_LOAD);
    assign is_store = (opcode == t08_pkg::OP_STORE);
    assign is_halt  = (opcode == t08_pkg::OP_SYSTEM);

endmodule

`default_nettype wire

/* source/t08_pc.sv */
`timescale 1ns/100ps
`default_nettype none

module t08_pc (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pc_advance,
    input  logic           pc_load,
    input  t08_pkg::word_t imm,
    output t08_pkg::word_t pc,
    t08_regs_if.dpath      regs
);

    t08_pkg::word_t instr_addr; // Address of the instruction in flight

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= t08_pkg::RESET_PC;
            instr_addr <= t08_pkg::RESET_PC;
        end else if (pc_advance) begin
            instr_addr <= pc;
            pc         <= pc + 32'd4;
        end else if (pc_load) begin
            pc <= instr_addr + imm; // Taken branch or jal
        end
    end

    assign regs.data_in_frominstructionfetch = pc; // Link address in EXECUTE

endmodule

`default_nettype wire

/* source/t08_control_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module t08_control_fsm (
    input  logic              clk,
    input  logic              rst_n,
    t08_regs_if.ctrl          regs,
    input  t08_pkg::branch_t  branch,
    input  logic              zero,
    input  logic              is_load,
    input  logic              is_store,
    input  logic              is_halt,
    input  t08_pkg::wb_sel_t  wb_sel,
    output logic              ir_load,
    output logic              pc_advance,
    output logic              pc_load,
    output logic              mem_read,
    output logic              mem_write,
    output logic              halted
);

    t08_pkg::cpu_state_t state, state_next;
    logic                started; // Low for the cycle in reset
    logic                taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= t08_pkg::FETCH;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (started) begin
                state <= state_next;
            end
        end
    end

    always_comb begin
        case (branch)
            t08_pkg::BR_BEQ: taken = zero;
            t08_pkg::BR_BNE: taken = !zero;
            t08_pkg::BR_JAL: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        state_next     = state;
        ir_load        = 1'b0;
        pc_advance     = 1'b0;
        pc_load        = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        halted         = 1'b0;
        regs.en_read_1 = 1'b0;
        regs.en_read_2 = 1'b0;
        regs.en_write  = 1'b0;
        if (started) begin
            case (state)
                t08_pkg::FETCH: begin
                    mem_read   = 1'b1;
                    ir_load    = 1'b1;
                    pc_advance = 1'b1;
                    state_next = t08_pkg::DECODE;
                end
                t08_pkg::DECODE: begin
                    regs.en_read_1 = 1'b1;
                    regs.en_read_2 = 1'b1;
                    state_next     = is_halt ? t08_pkg::HALT : t08_pkg::EXECUTE;
                end
                t08_pkg::EXECUTE: begin
                    regs.en_write = (wb_sel != t08_pkg::WB_ZERO) && !is_load;
                    pc_load       = taken;
                    state_next    = (is_load || is_store) ? t08_pkg::MEMORY : t08_pkg::FETCH;
                end
                t08_pkg::MEMORY: begin
                    mem_read      = is_load;
                    mem_write     = is_store;
                    regs.en_write = is_load; // Load data lands at closing edge
                    state_next    = t08_pkg::FETCH;
                end
                t08_pkg::HALT: halted = 1'b1; // Until reset
                default: state_next = t08_pkg::FETCH;
            endcase
        end
    end

    assign regs.data_in_control = regs.en_write ? wb_sel : t08_pkg::WB_ZERO;

endmodule

`default_nettype wire

/* source/t08_core.sv */
`timescale 1ns/100ps
`default_nettype none

module t08_core (
    input  logic           clk,
    input  logic           rst_n,
    output t08_pkg::word_t mem_addr,
    output t08_pkg::word_t mem_wdata,
    input  t08_pkg::word_t mem_rdata,
    output logic           mem_read,
    output logic           mem_write,
    output logic           halted
);

    t08_regs_if regs ();

    t08_pkg::alu_op_t alu_op;
    t08_pkg::wb_sel_t wb_sel;
    t08_pkg::branch_t branch;
    t08_pkg::word_t   imm;
    t08_pkg::word_t   pc;
    t08_pkg::word_t   alu_result;
    logic             use_imm;
    logic             zero;
    logic             is_load;
    logic             is_store;
    logic             is_halt;
    logic             ir_load;
    logic             pc_advance;
    logic             pc_load;

    assign regs.data_in_frommemory = mem_rdata;
    assign mem_wdata               = regs.data_out_r2; // Store data from rs2
    assign mem_addr                = ir_load ? pc : alu_result; // Fetch or data access

    t08_registers i_registers (
        .clk   (clk),
        .rst_n (rst_n),
        .regs  (regs.regfile)
    );

    t08_alu i_alu (
        .regs    (regs.dpath),
        .alu_op  (alu_op),
        .use_imm (use_imm),
        .imm     (imm),
        .result  (alu_result),
        .zero    (zero)
    );

    t08_decoder i_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .ir_load  (ir_load),
        .instr    (mem_rdata),
        .regs     (regs.dec),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .imm      (imm),
        .wb_sel   (wb_sel),
        .branch   (branch),
        .is_load  (is_load),
        .is_store (is_store),
        .is_halt  (is_halt)
    );

    t08_pc i_pc (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_advance (pc_advance),
        .pc_load    (pc_load),
        .imm        (imm),
        .pc         (pc),
        .regs       (regs.dpath)
    );

    t08_control_fsm i_control_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .regs       (regs.ctrl),
        .branch     (branch),
        .zero       (zero),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_halt    (is_halt),
        .wb_sel     (wb_sel),
        .ir_load    (ir_load),
        .pc_advance (pc_advance),
        .pc_load    (pc_load),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .halted     (halted)
    );

endmodule

`default_nettype wire

/* bench/t08_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module t08_core_tb;

    localparam int NUM_TESTS        = 6;
    localparam int MAX_INSTR        = 80;
    localparam int CYCLES_PER_INSTR = 4;
    localparam int MAX_CYCLES       = NUM_TESTS * MAX_INSTR * CYCLES_PER_INSTR * 5 / 4;
    localparam t08_pkg::word_t DATA_BASE = 32'h0000_0200; // Stores land above the code

    logic           clk = 1'b0;
    logic           rst_n;
    t08_pkg::word_t mem_addr;
    t08_pkg::word_t mem_wdata;
    t08_pkg::word_t mem_rdata;
    logic           mem_read;
    logic           mem_write;
    logic           halted;

    t08_pkg::word_t mem [1024];
    t08_pkg::word_t prog[$];
    t08_pkg::word_t exp_addr[$];
    t08_pkg::word_t exp_data[$];
    t08_pkg::word_t st_addr[$];
    t08_pkg::word_t st_data[$];
    t08_pkg::word_t lfsr_state;
    int             next_slot;
    int             errors = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    int             cycles = 0;

    t08_core i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .halted    (halted)
    );

    always #50 clk = ~clk;

    assign mem_rdata = mem_read ? mem[mem_addr[11:2]] : '0; // Memory answers at once

    always @(negedge clk) begin
        if (mem_write) begin
            mem[mem_addr[11:2]] = mem_wdata;
            st_addr.push_back(mem_addr);
            st_data.push_back(mem_wdata);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run took more than %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function logic lfsr_bit();
        logic b;
        b          = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function t08_pkg::word_t lfsr_word();
        t08_pkg::word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    // RV32I instruction formats
    function automatic t08_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], t08_pkg::OP_R};
    endfunction

    function automatic t08_pkg::word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic t08_pkg::word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], t08_pkg::OP_STORE};
    endfunction

    function automatic t08_pkg::word_t enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                t08_pkg::OP_BRANCH};
    endfunction

    function automatic t08_pkg::word_t enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], t08_pkg::OP_JAL};
    endfunction

    function automatic t08_pkg::word_t enc_u(logic [19:0] upper, int rd);
        return {upper, rd[4:0], t08_pkg::OP_LUI};
    endfunction

    function automatic t08_pkg::word_t slt_word(t08_pkg::word_t x, t08_pkg::word_t y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    task automatic check_word(input string name, input t08_pkg::word_t got,
                              input t08_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic emit(input t08_pkg::word_t instr);
        prog.push_back(instr);
    endtask

    task automatic prog_clear();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        next_slot = 0;
    endtask

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(input int rd, input t08_pkg::word_t value);
        t08_pkg::word_t up;
        up = value + 32'h800;
        emit(enc_u(up[31:12], rd));
        emit(enc_i(int'(value[11:0]), rd, 0, rd, t08_pkg::OP_I));
    endtask

    task automatic store_expect(input int rs2, input t08_pkg::word_t value);
        t08_pkg::word_t addr;
        addr = DATA_BASE + t08_pkg::word_t'(4 * next_slot);
        emit(enc_s(int'(addr[11:0]), rs2, 0));
        exp_addr.push_back(addr);
        exp_data.push_back(value);
        next_slot++;
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        check_flag("halted", halted, 1'b0);
        check_flag("mem_write", mem_write, 1'b0);
        check_flag("mem_read", mem_read, 1'b0);
        rst_n = 1'b1;
    endtask

    task automatic wait_halted();
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        repeat (4) begin // Core must stay quiet once halted
            @(negedge clk);
            check_flag("halted", halted, 1'b1);
            check_flag("mem_write", mem_write, 1'b0);
        end
    endtask

    task automatic run_program(input string name);
        int             errors_before;
        int             n;
        t08_pkg::word_t a;
        errors_before = errors;
        emit(enc_i(0, 0, 0, 0, t08_pkg::OP_SYSTEM)); // ecall
        for (int i = 0; i < 1024; i++) begin
            mem[i[9:0]] = 32'h6b5a_0000 | t08_pkg::word_t'(i);
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[i[9:0]] = prog[i];
        end
        st_addr.delete();
        st_data.delete();
        pulse_reset();
        wait_halted();
        if (st_addr.size() != exp_addr.size()) begin
            $display("Test %s made %0d stores instead of %0d", name, st_addr.size(),
                     exp_addr.size());
            errors++;
        end
        n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("mem_addr (store %0d)", i), st_addr[i], exp_addr[i]);
            check_word($sformatf("mem_wdata (store %0d)", i), st_data[i], exp_data[i]);
        end
        for (int i = 0; i < exp_addr.size(); i++) begin
            a = exp_addr[i];
            check_word($sformatf("memory word %h", a), mem[a[11:2]], exp_data[i]);
        end
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed", name);
            tests_failed++;
        end
    endtask

    task automatic r_op_store(input int f7, input int f3, input t08_pkg::word_t exp);
        emit(enc_r(f7, 2, 1, f3, 3));
        store_expect(3, exp);
    endtask

    task automatic i_op_store(input int f3, input int rs1, input int imm,
                              input t08_pkg::word_t exp);
        emit(enc_i(imm, rs1, f3, 5, t08_pkg::OP_I));
        store_expect(5, exp);
    endtask

    task automatic test_r_type();
        t08_pkg::word_t a;
        t08_pkg::word_t b;
        a = 32'hf0f0_1234;
        b = 32'h0000_0013;
        prog_clear();
        load_const(1, a);
        load_const(2, b);
        r_op_store(0, 0, a + b);
        r_op_store(32, 0, a - b);
        r_op_store(0, 7, a & b);
        r_op_store(0, 6, a | b);
        r_op_store(0, 4, a ^ b);
        r_op_store(0, 2, slt_word(a, b));
        r_op_store(0, 1, a << b[4:0]);
        r_op_store(0, 5, a >> b[4:0]);
        run_program("r_type");
    endtask

    task automatic test_immediates();
        t08_pkg::word_t a;
        a = 32'h1234_5678;
        prog_clear();
        load_const(1, a);
        load_const(4, 32'hffff_fffb); // -5
        i_op_store(0, 1, -100, a + t08_pkg::word_t'(-100));
        i_op_store(7, 1, -16, a & t08_pkg::word_t'(-16));
        i_op_store(6, 1, 240, a | t08_pkg::word_t'(240));
        i_op_store(4, 1, -1, a ^ t08_pkg::word_t'(-1));
        i_op_store(2, 1, -1, slt_word(a, t08_pkg::word_t'(-1)));
        i_op_store(2, 4, -3, slt_word(32'hffff_fffb, t08_pkg::word_t'(-3)));
        emit(enc_u(20'habcde, 6));
        store_expect(6, 32'habcd_e000);
        run_program("immediates");
    endtask

    task automatic test_load_store();
        t08_pkg::word_t v0;
        t08_pkg::word_t v1;
        v0 = 32'hcafe_0123;
        v1 = 32'h3c5a_9e71;
        prog_clear();
        load_const(1, v0);
        load_const(2, v1);
        load_const(8, DATA_BASE);
        store_expect(1, v0);
        store_expect(2, v1);
        store_expect(1, v0);
        emit(enc_i(4, 8, 2, 3, t08_pkg::OP_LOAD)); // lw x3, 4(x8)
        emit(enc_i(0, 8, 2, 4, t08_pkg::OP_LOAD));
        emit(enc_r(0, 4, 3, 0, 5));
        store_expect(5, v0 + v1);
        emit(enc_i(8, 8, 2, 6, t08_pkg::OP_LOAD));
        emit(enc_r(0, 2, 6, 4, 7));
        store_expect(7, v0 ^ v1);
        emit(enc_i(4, 8, 2, 9, t08_pkg::OP_LOAD));
        emit(enc_i(1, 9, 0, 9, t08_pkg::OP_I));
        store_expect(9, v1 + 32'd1);
        run_program("load_store");
    endtask

    task automatic test_control_flow();
        t08_pkg::word_t link;
        prog_clear();
        emit(enc_i(7, 0, 0, 1, t08_pkg::OP_I));
        emit(enc_i(7, 0, 0, 2, t08_pkg::OP_I));
        emit(enc_b(8, 2, 1, 0));       // beq taken
        emit(enc_s(int'(12'h3f0), 1, 0)); // Skipped store
        emit(enc_i(1, 0, 0, 3, t08_pkg::OP_I));
        emit(enc_b(8, 2, 1, 1));       // bne falls through
        store_expect(3, 32'd1);
        link = t08_pkg::word_t'(4 * prog.size() + 4);
        emit(enc_j(8, 4));
        emit(enc_s(int'(12'h3f4), 1, 0));
        store_expect(4, link);
        emit(enc_i(0, 0, 0, 5, t08_pkg::OP_I));
        emit(enc_i(5, 0, 0, 6, t08_pkg::OP_I));
        emit(enc_i(1, 5, 0, 5, t08_pkg::OP_I)); // Loop body
        emit(enc_b(-4, 6, 5, 1));
        store_expect(5, 32'd5);
        run_program("control_flow");
    endtask

    task automatic test_reg_zero();
        prog_clear();
        store_expect(1, 32'd0);  // Left over from earlier runs until reset
        store_expect(31, 32'd0);
        emit(enc_i(5, 0, 0, 0, t08_pkg::OP_I));
        emit(enc_u(20'h12345, 0));
        store_expect(0, 32'd0);
        emit(enc_i(9, 0, 0, 2, t08_pkg::OP_I));
        emit(enc_r(0, 2, 2, 0, 0));
        store_expect(0, 32'd0);
        store_expect(2, 32'd9);
        run_program("reg_zero");
    endtask

    task automatic test_random();
        t08_pkg::word_t a;
        t08_pkg::word_t b;
        prog_clear();
        for (int k = 0; k < 6; k++) begin
            a = lfsr_word();
            b = lfsr_word();
            load_const(1, a);
            load_const(2, b);
            r_op_store(0, 0, a + b);
            r_op_store(0, 4, a ^ b);
            r_op_store(32, 0, a - b);
        end
        run_program("random");
    endtask

    initial begin
        rst_n      = 1'b0;
        lfsr_state = 32'h4d75;
        test_r_type();
        test_immediates();
        test_load_store();
        test_control_flow();
        test_reg_zero();
        test_random();
        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
common/t08_pkg.sv
common/t08_regs_if.sv
registers/t08_registers.sv
source/t08_alu.sv
source/t08_decoder.sv
source/t08_pc.sv
source/t08_control_fsm.sv
source/t08_core.sv
bench/t08_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = t08_core_tb
FILELIST  = list.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /TB PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
